// ==== sim.f ====
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/gpr_file.sv
hw/reg_scoreboard.sv
hw/issue_check.sv
hw/operand_forward.sv
hw/dispatch_regs.sv
hw/dispatch_stage.sv
verif/tb_dispatch_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the dispatch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -f sim.f --top-module tb_dispatch_stage \
    -o tb_dispatch_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_dispatch_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation binary returned status $status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
    exit 0
fi
exit 1

// ==== verif/dispatch_golden.txt ====
# name stall flush | slot0 flags a b d imm | slot1 flags a b d imm | fwd mask dv addr data
# | expected accept valids dest0 dest1 op1_0 op2_0 op1_1 op2_1 (all hex)
load_r1 0 0 0 0 0 0 0 0 0 0 0 0 8 1 1 100 0 0 0 0 0 0 0 0
load_r2 0 0 0 0 0 0 0 0 0 0 0 0 8 1 2 200 0 0 0 0 0 0 0 0
load_r3 0 0 0 0 0 0 0 0 0 0 0 0 8 1 3 300 0 0 0 0 0 0 0 0
load_r4 0 0 0 0 0 0 0 0 0 0 0 0 8 1 4 400 0 0 0 0 0 0 0 0
indep_pair 0 0 d1 1 2 5 0 d1 3 4 6 0 0 0 0 0 3 3 5 6 100 200 300 400
raw_pair 0 0 d1 1 2 7 0 d1 7 3 8 0 0 0 0 0 1 1 7 0 100 200 0 0
raw_wait 0 0 d1 7 3 8 0 0 0 0 0 0 1 1 7 777 0 0 0 0 0 0 0 0
raw_issue 0 0 d1 7 3 8 0 0 0 0 0 0 8 1 7 777 1 1 8 0 777 300 0 0
mem_pair 0 0 d3 1 2 9 0 d1 3 4 a 0 0 0 0 0 1 1 9 0 100 200 0 0
mem_second 0 0 d1 3 4 a 0 0 0 0 0 0 0 0 0 0 1 1 a 0 300 400 0 0
priv_pair 0 0 d1 1 2 b 0 d5 3 4 c 0 0 0 0 0 1 1 b 0 100 200 0 0
bypass_prio 0 0 d1 2 0 d 0 71 2 0 e 1234 f 1 2 500 3 3 d e 500 0 500 1234
sb_block 0 0 d1 5 1 f 0 0 0 0 0 0 2 0 5 0 0 0 0 0 0 0 0 0
sb_still 0 0 d1 5 1 f 0 0 0 0 0 0 1 1 5 555 0 0 0 0 0 0 0 0
sb_release 0 0 d1 5 1 f 0 0 0 0 0 0 8 1 5 555 1 1 f 0 555 100 0 0
stall_hold 1 0 d1 1 2 10 0 0 0 0 0 0 0 0 0 0 0 1 f 0 555 100 0 0
flush_block 0 1 d1 6 1 11 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
flush_release 0 0 d1 6 1 11 0 0 0 0 0 0 0 0 0 0 1 1 11 0 0 100 0 0
idle 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// ==== verif/tb_dispatch_stage.sv ====
module tb_dispatch_stage
    import isa_pkg::*;
    import pipe_pkg::*;
;

    localparam int FWD_STAGES = 4;
    localparam int NFLD = 24;

    logic clk;
    logic rst_n;
    id_dispatch_t [ISSUE_WIDTH-1:0]                  id;
    logic                                            stall;
    logic                                            flush;
    data_forward_t [FWD_STAGES-1:0][ISSUE_WIDTH-1:0] fwd;
    logic [ISSUE_WIDTH-1:0]                          accept;
    dispatch_ex_t [ISSUE_WIDTH-1:0]                  exe;

    int    errors = 0;
    int    n_pass = 0;
    int    n_fail = 0;
    int    cycles = 0;
    int    cycle_limit = 0;
    string test_name;

    dispatch_stage #(.FWD_STAGES(FWD_STAGES)) u_dispatch_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_i     (id),
        .stall_i  (stall),
        .flush_i  (flush),
        .fwd_i    (fwd),
        .accept_o (accept),
        .exe_o    (exe)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit is set once the golden file has been counted
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, golden steps did not complete", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // Flag bits from bit 0 up are valid, mem, priv, excp, wreg, use_imm and two source valids
    function automatic id_dispatch_t build_instr(logic [31:0] flags, logic [31:0] a,
                                                 logic [31:0] b, logic [31:0] d,
                                                 logic [31:0] imm);
        id_dispatch_t ins;
        ins = '0;
        ins.valid       = flags[0];
        ins.mem         = flags[1];
        ins.priv        = flags[2];
        ins.excp        = flags[3];
        ins.wreg        = flags[4];
        ins.use_imm     = flags[5];
        ins.src_valid   = flags[7:6];
        ins.src_addr[0] = a[4:0];
        ins.src_addr[1] = b[4:0];
        ins.wreg_addr   = d[4:0];
        ins.imm         = imm;
        ins.pc          = 32'h1000;
        ins.alu_op      = ALU_OP_ADD;
        ins.alu_sel     = ALU_SEL_ARITH;
        return ins;
    endfunction

    // Youngest marked stage carries base and each older marked stage adds one more
    task automatic drive_bypass(logic [31:0] mask, logic [31:0] dv, logic [31:0] addr,
                                logic [31:0] base);
        logic [31:0] offset;
        offset = '0;
        fwd = '0;
        for (int s = 0; s < FWD_STAGES; s++) begin
            if (mask[s]) begin
                fwd[s][0].wreg       = 1'b1;
                fwd[s][0].data_valid = dv[0];
                fwd[s][0].wreg_addr  = addr[4:0];
                fwd[s][0].wreg_data  = base + offset;
                offset++;
            end
        end
    endtask

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        assert (expected == actual)
        else begin
            $display("mismatch %s %s expected %h actual %h", test_name, what, expected,
                     actual);
            errors++;
        end
    endtask

    initial begin
        int          fd;
        int          steps;
        int          n;
        int          n_read;
        int          errors_before;
        string       line;
        logic [31:0] fld [NFLD];

        rst_n = 1'b0;
        id    = '0;
        stall = 1'b0;
        flush = 1'b0;
        fwd   = '0;

        // Count steps first to size the run limit
        steps = 0;
        fd = $fopen("verif/dispatch_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/dispatch_golden.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line[0] != "#") begin
                    steps++;
                end
            end
            $fclose(fd);
            cycle_limit = 4 * steps + 50;

            repeat (10) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;

            fd = $fopen("verif/dispatch_golden.txt", "r");
            n = $fscanf(fd, "%s", test_name);
            while (n == 1) begin
                if (test_name[0] == "#") begin
                    // Rest of a comment line
                    n = $fgets(line, fd);
                end else begin
                    n_read = 0;
                    for (int k = 0; k < NFLD; k++) begin
                        n_read += $fscanf(fd, "%h", fld[k]);
                    end
                    if (n_read != NFLD) begin
                        $display("golden line %s is malformed", test_name);
                        errors++;
                        n_fail++;
                    end else begin
                        errors_before = errors;
                        stall = fld[0][0];
                        flush = fld[1][0];
                        id[0] = build_instr(fld[2], fld[3], fld[4], fld[5], fld[6]);
                        id[1] = build_instr(fld[7], fld[8], fld[9], fld[10], fld[11]);
                        drive_bypass(fld[12], fld[13], fld[14], fld[15]);
                        #1;
                        check_value("accept", fld[16], 32'(accept));
                        @(negedge clk);
                        check_value("valids", fld[17], 32'({exe[1].valid, exe[0].valid}));
                        check_value("dest0", fld[18], 32'(exe[0].wreg_addr));
                        check_value("dest1", fld[19], 32'(exe[1].wreg_addr));
                        check_value("op1_slot0", fld[20], exe[0].oprand1);
                        check_value("op2_slot0", fld[21], exe[0].oprand2);
                        check_value("op1_slot1", fld[22], exe[1].oprand1);
                        check_value("op2_slot1", fld[23], exe[1].oprand2);
                        if (errors == errors_before) begin
                            $display("test %s ok", test_name);
                            n_pass++;
                        end else begin
                            $display("test %s bad", test_name);
                            n_fail++;
                        end
                    end
                end
                n = $fscanf(fd, "%s", test_name);
            end
            $fclose(fd);

            $display("tests ok %0d, tests bad %0d", n_pass, n_fail);
            if (errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

// ==== hw/dispatch_stage.sv ====
module dispatch_stage
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int FWD_STAGES = 4
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  id_dispatch_t [ISSUE_WIDTH-1:0]                  id_i,
    input  logic                                            stall_i,
    input  logic                                            flush_i,
    input  data_forward_t [FWD_STAGES-1:0][ISSUE_WIDTH-1:0] fwd_i,
    output logic [ISSUE_WIDTH-1:0]                          accept_o,
    output dispatch_ex_t [ISSUE_WIDTH-1:0]                  exe_o
);

    reg_addr_t [2*ISSUE_WIDTH-1:0] src_addr;
    data_t [2*ISSUE_WIDTH-1:0]     rf_data;
    data_t [2*ISSUE_WIDTH-1:0]     opnd;
    logic [2*ISSUE_WIDTH-1:0]      src_avail;
    logic [ISSUE_WIDTH-1:0]        issue;
    logic [ISSUE_WIDTH-1:0]        wen;
    reg_addr_t [ISSUE_WIDTH-1:0]   dest;
    logic [ISSUE_WIDTH-1:0]        rf_we;
    reg_addr_t [ISSUE_WIDTH-1:0]   rf_waddr;
    data_t [ISSUE_WIDTH-1:0]       rf_wdata;

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_slot
        assign src_addr[2*i]     = id_i[i].src_addr[0];
        assign src_addr[2*i + 1] = id_i[i].src_addr[1];
        assign wen[i]            = id_i[i].wreg;
        assign dest[i]           = id_i[i].wreg_addr;
        // Final WB results land in the register file
        assign rf_we[i]    = fwd_i[FWD_STAGES-1][i].wreg & fwd_i[FWD_STAGES-1][i].data_valid;
        assign rf_waddr[i] = fwd_i[FWD_STAGES-1][i].wreg_addr;
        assign rf_wdata[i] = fwd_i[FWD_STAGES-1][i].wreg_data;
    end

    gpr_file u_gpr_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (src_addr),
        .rdata_o (rf_data)
    );

    for (genvar k = 0; k < 2 * ISSUE_WIDTH; k++) begin : g_fwd
        operand_forward #(.FWD_STAGES(FWD_STAGES)) u_operand_forward (
            .addr_i    (src_addr[k]),
            .rf_data_i (rf_data[k]),
            .fwd_i     (fwd_i),
            .data_o    (opnd[k])
        );
    end

    reg_scoreboard #(.FWD_STAGES(FWD_STAGES)) u_reg_scoreboard (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .fwd_i       (fwd_i),
        .issue_i     (issue),
        .dest_i      (dest),
        .wen_i       (wen),
        .src_addr_i  (src_addr),
        .src_avail_o (src_avail)
    );

    issue_check u_issue_check (
        .stall_i     (stall_i),
        .id_i        (id_i),
        .src_avail_i (src_avail),
        .issue_o     (issue),
        .accept_o    (accept_o)
    );

    dispatch_regs u_dispatch_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .issue_i (issue),
        .id_i    (id_i),
        .opnd_i  (opnd),
        .exe_o   (exe_o)
    );

endmodule

// ==== hw/dispatch_regs.sv ====
module dispatch_regs
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            stall_i,
    input  logic                            flush_i,
    input  logic [ISSUE_WIDTH-1:0]          issue_i,
    input  id_dispatch_t [ISSUE_WIDTH-1:0]  id_i,
    input  data_t [2*ISSUE_WIDTH-1:0]       opnd_i,
    output dispatch_ex_t [ISSUE_WIDTH-1:0]  exe_o
);

    dispatch_ex_t [ISSUE_WIDTH-1:0] exe_d;

    // Non-issued slots become bubbles
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            exe_d[i] = '0;
            if (issue_i[i]) begin
                exe_d[i].valid     = 1'b1;
                exe_d[i].pc        = id_i[i].pc;
                exe_d[i].alu_op    = id_i[i].alu_op;
                exe_d[i].alu_sel   = id_i[i].alu_sel;
                exe_d[i].wreg      = id_i[i].wreg;
                exe_d[i].wreg_addr = id_i[i].wreg_addr;
                exe_d[i].oprand1   = opnd_i[2*i];
                exe_d[i].oprand2   = id_i[i].use_imm ? id_i[i].imm : opnd_i[2*i + 1];
                exe_d[i].imm       = id_i[i].imm;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            exe_o <= '0;
        end else if (!stall_i) begin
            exe_o <= exe_d;
        end
    end

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> (!exe_o[0].valid && !exe_o[1].valid))
        else $error("execute slot valid after flush");

endmodule

// ==== hw/operand_forward.sv ====
module operand_forward
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int FWD_STAGES = 4
) (
    input  reg_addr_t                                       addr_i,
    input  data_t                                           rf_data_i,
    input  data_forward_t [FWD_STAGES-1:0][ISSUE_WIDTH-1:0] fwd_i,
    output data_t                                           data_o
);

    // Walk from WB toward EX, so the youngest match is kept
    always_comb begin
        data_o = rf_data_i;
        for (int s = FWD_STAGES - 1; s >= 0; s--) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (fwd_i[s][i].wreg && fwd_i[s][i].wreg_addr == addr_i) begin
                    data_o = fwd_i[s][i].wreg_data;
                end
            end
        end
        // r0 reads zero
        if (addr_i == '0) begin
            data_o = '0;
        end
    end

endmodule

// ==== hw/issue_check.sv ====
module issue_check
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                            stall_i,
    input  id_dispatch_t [ISSUE_WIDTH-1:0]  id_i,
    input  logic [2*ISSUE_WIDTH-1:0]        src_avail_i,
    output logic [ISSUE_WIDTH-1:0]          issue_o,
    output logic [ISSUE_WIDTH-1:0]          accept_o
);

    logic [ISSUE_WIDTH-1:0] src_ok;
    logic                   single_only;
    logic                   raw_hazard;

    // Only sources actually used must be available
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            src_ok[i] = 1'b1;
            for (int j = 0; j < 2; j++) begin
                if (id_i[i].src_valid[j] && !src_avail_i[2*i + j]) begin
                    src_ok[i] = 1'b0;
                end
            end
        end
    end

    // Mem, privileged and excepting instructions go alone
    assign single_only = id_i[0].mem | id_i[0].priv | id_i[0].excp
                       | id_i[1].mem | id_i[1].priv | id_i[1].excp;

    // Slot 1 reading what slot 0 writes
    always_comb begin
        raw_hazard = 1'b0;
        for (int j = 0; j < 2; j++) begin
            if (id_i[0].wreg && id_i[1].src_valid[j]
                && id_i[1].src_addr[j] == id_i[0].wreg_addr) begin
                raw_hazard = 1'b1;
            end
        end
    end

    assign issue_o[0] = id_i[0].valid & src_ok[0];
    assign issue_o[1] = issue_o[0] & id_i[1].valid & src_ok[1] & ~single_only & ~raw_hazard;

    // Stall only gates the buffer side
    assign accept_o = stall_i ? '0 : issue_o;

    always_comb begin
        a_in_order: assert (!accept_o[1] || accept_o[0])
            else $error("slot 1 accepted without slot 0");
    end

endmodule

// ==== hw/reg_scoreboard.sv ====
module reg_scoreboard
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int FWD_STAGES = 4
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            stall_i,
    input  logic                                            flush_i,
    input  data_forward_t [FWD_STAGES-1:0][ISSUE_WIDTH-1:0] fwd_i,
    input  logic [ISSUE_WIDTH-1:0]                          issue_i,
    input  reg_addr_t [ISSUE_WIDTH-1:0]                     dest_i,
    input  logic [ISSUE_WIDTH-1:0]                          wen_i,
    input  reg_addr_t [2*ISSUE_WIDTH-1:0]                   src_addr_i,
    output logic [2*ISSUE_WIDTH-1:0]                        src_avail_o
);

    logic [GPR_NUM-1:0] avail_q;
    logic [GPR_NUM-1:0] avail_d;

    // Register 0 is never tracked, so writers to it leave its bit alone
    always_comb begin
        avail_d = avail_q;
        // Oldest stage first so younger entries override
        for (int s = FWD_STAGES - 1; s >= 0; s--) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (fwd_i[s][i].wreg && fwd_i[s][i].wreg_addr != '0) begin
                    avail_d[fwd_i[s][i].wreg_addr] = fwd_i[s][i].data_valid;
                end
            end
        end
        // Newly issued writers go busy
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (issue_i[i] && wen_i[i] && dest_i[i] != '0) begin
                avail_d[dest_i[i]] = 1'b0;
            end
        end
    end

    // Flush drops all pending writers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            avail_q <= '1;
        end else if (flush_i) begin
            avail_q <= '1;
        end else if (!stall_i) begin
            avail_q <= avail_d;
        end
    end

    always_comb begin
        for (int k = 0; k < 2 * ISSUE_WIDTH; k++) begin
            src_avail_o[k] = avail_q[src_addr_i[k]];
        end
    end

    a_r0_avail: assert property (@(posedge clk) disable iff (!rst_n) avail_q[0])
        else $error("register 0 marked busy");

endmodule

// ==== hw/gpr_file.sv ====
module gpr_file
    import isa_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [ISSUE_WIDTH-1:0]              we_i,
    input  reg_addr_t [ISSUE_WIDTH-1:0]         waddr_i,
    input  data_t [ISSUE_WIDTH-1:0]             wdata_i,
    input  reg_addr_t [2*ISSUE_WIDTH-1:0]       raddr_i,
    output data_t [2*ISSUE_WIDTH-1:0]           rdata_o
);

    data_t regs [GPR_NUM];

    // Port 1 is applied last so it wins on a shared address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < GPR_NUM; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < ISSUE_WIDTH; p++) begin
                if (we_i[p] && waddr_i[p] != '0) begin
                    regs[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // Register 0 is never written, so it reads zero
    always_comb begin
        for (int k = 0; k < 2 * ISSUE_WIDTH; k++) begin
            rdata_o[k] = regs[raddr_i[k]];
        end
    end

endmodule

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

    import isa_pkg::*;

    // Decoded instruction from the instruction buffer
    typedef struct packed {
        logic                 valid;
        data_t                pc;
        // Load or store
        logic                 mem;
        logic                 priv;
        logic                 excp;
        alu_op_e              alu_op;
        alu_sel_e             alu_sel;
        logic [1:0]           src_valid;
        reg_addr_t [1:0]      src_addr;
        logic                 wreg;
        reg_addr_t            wreg_addr;
        logic                 use_imm;
        data_t                imm;
    } id_dispatch_t;

    // One bypass entry from a later stage
    typedef struct packed {
        logic      wreg;
        // Value is final, not a load still in flight
        logic      data_valid;
        reg_addr_t wreg_addr;
        data_t     wreg_data;
    } data_forward_t;

    // Issued instruction toward execute
    typedef struct packed {
        logic     valid;
        data_t    pc;
        alu_op_e  alu_op;
        alu_sel_e alu_sel;
        logic     wreg;
        reg_addr_t wreg_addr;
        data_t    oprand1;
        data_t    oprand2;
        data_t    imm;
    } dispatch_ex_t;

endpackage

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    parameter int DATA_WIDTH     = 32;
    parameter int REG_ADDR_WIDTH = 5;
    parameter int GPR_NUM        = 32;
    parameter int ISSUE_WIDTH    = 2;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;

    // Operation code carried from decode to execute
    typedef enum logic [7:0] {
        ALU_OP_NOP  = 8'h00,
        ALU_OP_ADD  = 8'h01,
        ALU_OP_SUB  = 8'h02,
        ALU_OP_AND  = 8'h03,
        ALU_OP_OR   = 8'h04,
        ALU_OP_XOR  = 8'h05,
        ALU_OP_SLL  = 8'h06,
        ALU_OP_SRL  = 8'h07,
        ALU_OP_SRA  = 8'h08,
        ALU_OP_SLT  = 8'h09,
        ALU_OP_LOAD = 8'h10,
        ALU_OP_STOR = 8'h11,
        ALU_OP_BR   = 8'h20
    } alu_op_e;

    // Functional unit select
    typedef enum logic [2:0] {
        ALU_SEL_NOP   = 3'd0,
        ALU_SEL_ARITH = 3'd1,
        ALU_SEL_LOGIC = 3'd2,
        ALU_SEL_SHIFT = 3'd3,
        ALU_SEL_MEM   = 3'd4,
        ALU_SEL_BRAN  = 3'd5
    } alu_sel_e;

endpackage
